// ==== hw/video_macros.svh ====
// Active area and register map; shrink the active size for short simulations, pitch <= 64 words.
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ====================
// Screen geometry.
// ====================
`define VIDEO_ACTIVE_WIDTH 64
`define VIDEO_ACTIVE_HEIGHT 16

// Line buffer depth in 32-bit words.
`define VIDEO_MAX_PITCH_WORDS 64
`define VIDEO_PALETTE_SIZE 256

// ====================
// Control register byte offsets, palette window below 0x400.
// ====================
`define VIDEO_REG_READ_OFFSET 12'h400
`define VIDEO_REG_PITCH 12'h404
`define VIDEO_REG_SKIP_X 12'h408
`define VIDEO_REG_SKIP_Y 12'h40C
`define VIDEO_REG_USE_PALETTE 12'h410

`endif

// ==== hw/video_bus_pkg.sv ====
// CPU bus types; only OKAY and SLVERR responses are ever produced, addresses are 12-bit bytes.
package video_bus_pkg;

	// AXI4-Lite response codes.
	typedef enum logic [1:0] {
		AXIL_OKAY = 2'b00,
		AXIL_SLVERR = 2'b10
	} axil_resp_t;

	// Byte address inside the 4 KiB register space.
	typedef logic [11:0] reg_addr_t;

endpackage

// ==== hw/video_pixel_pkg.sv ====
// Pixel path types; line index width follows the line buffer depth in the macros header.
`include "video_macros.svh"

package video_pixel_pkg;

	localparam int LINE_INDEX_WIDTH = $clog2(`VIDEO_MAX_PITCH_WORDS);

	// Red in the upper byte.
	typedef logic [23:0] rgb_t;

	typedef logic [31:0] vram_word_t;

	typedef logic [7:0] pal_index_t;

	// Word slot inside the line buffer.
	typedef logic [LINE_INDEX_WIDTH-1:0] line_index_t;

	// Screen position, up to 2047.
	typedef logic [10:0] coord_t;

endpackage

// ==== hw/video_dual_port_ram.sv ====
// Registered read, no reset; a read of the address written in the same cycle returns old data.
`timescale 1ns/1ps

module video_dual_port_ram #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 64
) (
	input logic i_clock,
	input logic i_we,
	input logic [$clog2(DEPTH)-1:0] i_waddr,
	input payload_t i_wdata,
	input logic [$clog2(DEPTH)-1:0] i_raddr,
	output payload_t o_rdata
);

	payload_t mem [DEPTH];

	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		// Old contents win on a same-address collision.
		o_rdata <= mem[i_raddr];
	end

endmodule

// ==== hw/video_axil_regs.sv ====
// AXI4-Lite slave, one outstanding write and one outstanding read; palette is write-only.
`timescale 1ns/1ps
`include "video_macros.svh"

module video_axil_regs (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_awvalid,
	input video_bus_pkg::reg_addr_t i_awaddr,
	output logic o_awready,
	input logic i_wvalid,
	input video_pixel_pkg::vram_word_t i_wdata,
	output logic o_wready,
	output logic o_bvalid,
	output video_bus_pkg::axil_resp_t o_bresp,
	input logic i_bready,
	input logic i_arvalid,
	input video_bus_pkg::reg_addr_t i_araddr,
	output logic o_arready,
	output logic o_rvalid,
	output video_pixel_pkg::vram_word_t o_rdata,
	output video_bus_pkg::axil_resp_t o_rresp,
	input logic i_rready,
	output logic o_pal_we,
	output video_pixel_pkg::pal_index_t o_pal_index,
	output video_pixel_pkg::rgb_t o_pal_color,
	output video_pixel_pkg::vram_word_t o_read_offset,
	output logic [$bits(video_pixel_pkg::line_index_t):0] o_pitch,
	output video_pixel_pkg::coord_t o_skip_x,
	output video_pixel_pkg::coord_t o_skip_y,
	output logic o_use_palette
);

	localparam int PITCH_W = $bits(video_pixel_pkg::line_index_t) + 1;

	logic ready_en;
	logic aw_held;
	logic w_held;
	video_bus_pkg::reg_addr_t aw_addr_q;
	video_pixel_pkg::vram_word_t w_data_q;
	logic commit;
	logic pal_window;
	video_pixel_pkg::vram_word_t rd_data_next;
	video_bus_pkg::axil_resp_t rd_resp_next;

	// ====================
	// Write channel.
	// ====================

	// Ready comes up one cycle after reset.
	assign o_awready = ready_en && !aw_held && !o_bvalid;
	assign o_wready = ready_en && !w_held && !o_bvalid;

	assign commit = aw_held && w_held;
	assign pal_window = (aw_addr_q[11:10] == 2'b00);

	assign o_pal_we = commit && pal_window;
	assign o_pal_index = aw_addr_q[9:2];
	assign o_pal_color = w_data_q[23:0];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			ready_en <= 1'b0;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			o_bvalid <= 1'b0;
			o_bresp <= video_bus_pkg::AXIL_OKAY;
			o_read_offset <= '0;
			o_pitch <= PITCH_W'(`VIDEO_MAX_PITCH_WORDS);
			o_skip_x <= '0;
			o_skip_y <= '0;
			o_use_palette <= 1'b1;
		end else begin
			ready_en <= 1'b1;
			if (i_awvalid && o_awready) begin
				aw_held <= 1'b1;
				aw_addr_q <= i_awaddr;
			end
			if (i_wvalid && o_wready) begin
				w_held <= 1'b1;
				w_data_q <= i_wdata;
			end
			if (o_bvalid && i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (commit) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				o_bvalid <= 1'b1;
				o_bresp <= video_bus_pkg::AXIL_OKAY;
				if (!pal_window) begin
					case (aw_addr_q)
						`VIDEO_REG_READ_OFFSET: o_read_offset <= w_data_q;
						// Clip to the line buffer depth.
						`VIDEO_REG_PITCH: begin
							if (w_data_q > `VIDEO_MAX_PITCH_WORDS) begin
								o_pitch <= PITCH_W'(`VIDEO_MAX_PITCH_WORDS);
							end else begin
								o_pitch <= w_data_q[PITCH_W-1:0];
							end
						end
						`VIDEO_REG_SKIP_X: o_skip_x <= w_data_q[10:0];
						`VIDEO_REG_SKIP_Y: o_skip_y <= w_data_q[10:0];
						`VIDEO_REG_USE_PALETTE: o_use_palette <= w_data_q[0];
						default: o_bresp <= video_bus_pkg::AXIL_SLVERR;
					endcase
				end
			end
		end
	end

	// ====================
	// Read channel.
	// ====================

	assign o_arready = !o_rvalid;

	always_comb begin
		rd_data_next = '0;
		rd_resp_next = video_bus_pkg::AXIL_OKAY;
		case (i_araddr)
			`VIDEO_REG_READ_OFFSET: rd_data_next = o_read_offset;
			`VIDEO_REG_PITCH: rd_data_next = 32'(o_pitch);
			`VIDEO_REG_SKIP_X: rd_data_next = 32'(o_skip_x);
			`VIDEO_REG_SKIP_Y: rd_data_next = 32'(o_skip_y);
			`VIDEO_REG_USE_PALETTE: rd_data_next = 32'(o_use_palette);
			// Palette window and holes.
			default: rd_resp_next = video_bus_pkg::AXIL_SLVERR;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_rvalid <= 1'b0;
		end else begin
			if (i_arvalid && o_arready) begin
				o_rvalid <= 1'b1;
				o_rdata <= rd_data_next;
				o_rresp <= rd_resp_next;
			end else if (o_rvalid && i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/video_line_fetch.sv ====
// Fetches one row per hblank; an hblank edge during a running fetch starts no new fetch.
`timescale 1ns/1ps
`include "video_macros.svh"

module video_line_fetch (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_hblank,
	input logic i_vblank,
	input video_pixel_pkg::vram_word_t i_read_offset,
	input logic [$bits(video_pixel_pkg::line_index_t):0] i_pitch,
	input video_pixel_pkg::coord_t i_skip_y,
	output logic o_vram_request,
	output video_pixel_pkg::vram_word_t o_vram_address,
	input video_pixel_pkg::vram_word_t i_vram_rdata,
	input logic i_vram_ready,
	output logic o_line_we,
	output video_pixel_pkg::line_index_t o_line_index,
	output video_pixel_pkg::vram_word_t o_line_word
);

	localparam int PITCH_W = $bits(video_pixel_pkg::line_index_t) + 1;

	logic [1:0] hs;
	logic [1:0] vs;
	video_pixel_pkg::coord_t row;
	video_pixel_pkg::vram_word_t row_base;
	logic [PITCH_W-1:0] word_cnt;
	logic row_active;

	// Row lies inside the vertical window.
	assign row_active = (row >= i_skip_y) &&
		(({1'b0, row} + {1'b0, i_skip_y}) < 12'(`VIDEO_ACTIVE_HEIGHT));

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			hs <= 2'b00;
			vs <= 2'b00;
			row <= '0;
			row_base <= '0;
			word_cnt <= '0;
			o_vram_request <= 1'b0;
			o_line_we <= 1'b0;
		end else begin
			hs <= {hs[0], i_hblank};
			vs <= {vs[0], i_vblank};
			o_line_we <= 1'b0;

			// Start of frame.
			if (vs == 2'b01) begin
				row <= '0;
				row_base <= '0;
			end else if (hs == 2'b01 && vs == 2'b00) begin
				if (row_active) begin
					row_base <= row_base + 32'({i_pitch, 2'b00});
					if (!o_vram_request && i_pitch != '0) begin
						o_vram_request <= 1'b1;
						o_vram_address <= i_read_offset + row_base;
						word_cnt <= '0;
					end
				end
				row <= row + 1'b1;
			end

			// One line buffer word per accepted beat.
			if (o_vram_request && i_vram_ready) begin
				o_line_we <= 1'b1;
				o_line_index <= word_cnt[PITCH_W-2:0];
				o_line_word <= i_vram_rdata;
				if ((word_cnt + 1'b1) < i_pitch) begin
					o_vram_address <= o_vram_address + 32'd4;
					word_cnt <= word_cnt + 1'b1;
				end else begin
					o_vram_request <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== hw/video_pixel_out.sv ====
// Two-cycle pixel pipeline, position in cycle t gives o_pixel after the edge ending t+2.
`timescale 1ns/1ps
`include "video_macros.svh"

module video_pixel_out (
	input logic i_clock,
	input logic i_rst_n,
	input video_pixel_pkg::coord_t i_pos_x,
	input video_pixel_pkg::coord_t i_pos_y,
	input video_pixel_pkg::coord_t i_skip_x,
	input video_pixel_pkg::coord_t i_skip_y,
	input logic i_use_palette,
	output video_pixel_pkg::line_index_t o_line_index,
	input video_pixel_pkg::vram_word_t i_line_word,
	output video_pixel_pkg::pal_index_t o_pal_index,
	input video_pixel_pkg::rgb_t i_pal_color,
	output video_pixel_pkg::rgb_t o_pixel
);

	video_pixel_pkg::coord_t u;
	logic in_window;
	logic [1:0] sel_q;
	logic valid_q;
	logic valid_q2;
	logic pal_mode_q;
	logic pal_mode_q2;
	video_pixel_pkg::vram_word_t word_q;

	// ====================
	// Stage 0, window and line index.
	// ====================
	assign u = i_pos_x - i_skip_x;

	assign in_window = (i_pos_x >= i_skip_x) &&
		(({1'b0, i_pos_x} + {1'b0, i_skip_x}) < 12'(`VIDEO_ACTIVE_WIDTH)) &&
		(i_pos_y >= i_skip_y) &&
		(({1'b0, i_pos_y} + {1'b0, i_skip_y}) < 12'(`VIDEO_ACTIVE_HEIGHT));

	// Four pixels per word in palette mode.
	assign o_line_index = i_use_palette ?
		video_pixel_pkg::line_index_t'(u >> 2) :
		video_pixel_pkg::line_index_t'(u);

	// ====================
	// Stage 1, byte select into the palette.
	// ====================
	always_comb begin
		case (sel_q)
			2'd0: o_pal_index = i_line_word[7:0];
			2'd1: o_pal_index = i_line_word[15:8];
			2'd2: o_pal_index = i_line_word[23:16];
			default: o_pal_index = i_line_word[31:24];
		endcase
	end

	// Payload follows the RAM outputs.
	always_ff @(posedge i_clock) begin
		sel_q <= u[1:0];
		word_q <= i_line_word;
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			valid_q2 <= 1'b0;
			pal_mode_q <= 1'b0;
			pal_mode_q2 <= 1'b0;
			o_pixel <= '0;
		end else begin
			valid_q <= in_window;
			valid_q2 <= valid_q;
			pal_mode_q <= i_use_palette;
			pal_mode_q2 <= pal_mode_q;
			// Stage 2, black outside the window.
			if (!valid_q2) begin
				o_pixel <= '0;
			end else if (pal_mode_q2) begin
				o_pixel <= i_pal_color;
			end else begin
				o_pixel <= word_q[23:0];
			end
		end
	end

endmodule

// ==== hw/video_controller_top.sv ====
// Scan-out controller top; VRAM is read-only here and the palette is written only over AXI4-Lite.
`timescale 1ns/1ps
`include "video_macros.svh"

module video_controller_top (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_awvalid,
	input video_bus_pkg::reg_addr_t i_awaddr,
	output logic o_awready,
	input logic i_wvalid,
	input video_pixel_pkg::vram_word_t i_wdata,
	output logic o_wready,
	output logic o_bvalid,
	output video_bus_pkg::axil_resp_t o_bresp,
	input logic i_bready,
	input logic i_arvalid,
	input video_bus_pkg::reg_addr_t i_araddr,
	output logic o_arready,
	output logic o_rvalid,
	output video_pixel_pkg::vram_word_t o_rdata,
	output video_bus_pkg::axil_resp_t o_rresp,
	input logic i_rready,
	input logic i_hblank,
	input logic i_vblank,
	input video_pixel_pkg::coord_t i_pos_x,
	input video_pixel_pkg::coord_t i_pos_y,
	output logic o_vram_request,
	output video_pixel_pkg::vram_word_t o_vram_address,
	input video_pixel_pkg::vram_word_t i_vram_rdata,
	input logic i_vram_ready,
	output video_pixel_pkg::rgb_t o_pixel
);

	logic pal_we;
	video_pixel_pkg::pal_index_t pal_windex;
	video_pixel_pkg::rgb_t pal_wcolor;
	video_pixel_pkg::pal_index_t pal_rindex;
	video_pixel_pkg::rgb_t pal_rcolor;
	video_pixel_pkg::vram_word_t read_offset;
	logic [$bits(video_pixel_pkg::line_index_t):0] pitch;
	video_pixel_pkg::coord_t skip_x;
	video_pixel_pkg::coord_t skip_y;
	logic use_palette;
	logic line_we;
	video_pixel_pkg::line_index_t line_windex;
	video_pixel_pkg::vram_word_t line_wword;
	video_pixel_pkg::line_index_t line_rindex;
	video_pixel_pkg::vram_word_t line_rword;

	// ====================
	// CPU side.
	// ====================
	video_axil_regs u_regs (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_awvalid(i_awvalid),
		.i_awaddr(i_awaddr),
		.o_awready(o_awready),
		.i_wvalid(i_wvalid),
		.i_wdata(i_wdata),
		.o_wready(o_wready),
		.o_bvalid(o_bvalid),
		.o_bresp(o_bresp),
		.i_bready(i_bready),
		.i_arvalid(i_arvalid),
		.i_araddr(i_araddr),
		.o_arready(o_arready),
		.o_rvalid(o_rvalid),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.i_rready(i_rready),
		.o_pal_we(pal_we),
		.o_pal_index(pal_windex),
		.o_pal_color(pal_wcolor),
		.o_read_offset(read_offset),
		.o_pitch(pitch),
		.o_skip_x(skip_x),
		.o_skip_y(skip_y),
		.o_use_palette(use_palette)
	);

	video_dual_port_ram #(
		.payload_t(video_pixel_pkg::rgb_t),
		.DEPTH(`VIDEO_PALETTE_SIZE)
	) palette_ram (
		.i_clock(i_clock),
		.i_we(pal_we),
		.i_waddr(pal_windex),
		.i_wdata(pal_wcolor),
		.i_raddr(pal_rindex),
		.o_rdata(pal_rcolor)
	);

	// ====================
	// Video side.
	// ====================
	video_line_fetch u_fetch (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_hblank(i_hblank),
		.i_vblank(i_vblank),
		.i_read_offset(read_offset),
		.i_pitch(pitch),
		.i_skip_y(skip_y),
		.o_vram_request(o_vram_request),
		.o_vram_address(o_vram_address),
		.i_vram_rdata(i_vram_rdata),
		.i_vram_ready(i_vram_ready),
		.o_line_we(line_we),
		.o_line_index(line_windex),
		.o_line_word(line_wword)
	);

	video_dual_port_ram #(
		.payload_t(video_pixel_pkg::vram_word_t),
		.DEPTH(`VIDEO_MAX_PITCH_WORDS)
	) line_ram (
		.i_clock(i_clock),
		.i_we(line_we),
		.i_waddr(line_windex),
		.i_wdata(line_wword),
		.i_raddr(line_rindex),
		.o_rdata(line_rword)
	);

	video_pixel_out u_pixel (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_pos_x(i_pos_x),
		.i_pos_y(i_pos_y),
		.i_skip_x(skip_x),
		.i_skip_y(skip_y),
		.i_use_palette(use_palette),
		.o_line_index(line_rindex),
		.i_line_word(line_rword),
		.o_pal_index(pal_rindex),
		.i_pal_color(pal_rcolor),
		.o_pixel(o_pixel)
	);

endmodule

// ==== sim/tb_video_controller.sv ====
// Needs the small active area from the macros header; VRAM data is the address XOR a constant.
`timescale 1ns/1ps
`include "video_macros.svh"

module tb_video_controller;

	localparam int W = `VIDEO_ACTIVE_WIDTH;
	localparam int H = `VIDEO_ACTIVE_HEIGHT;
	localparam int MAXP = `VIDEO_MAX_PITCH_WORDS;
	localparam logic [31:0] VRAM_XOR = 32'h5A3C_96E1;

	// ====================
	// Run length bound.
	// ====================
	localparam int ROW_CYCLES = 8 + MAXP * 5 + W;
	localparam int FRAME_CYCLES = 16 + H * ROW_CYCLES;
	localparam int AXI_CYCLES = 24;
	localparam int AXI_COUNT = 400;
	localparam int CYCLE_LIMIT = 4 * FRAME_CYCLES + AXI_COUNT * AXI_CYCLES + 100;

	logic i_clock;
	logic i_rst_n;
	logic i_awvalid;
	video_bus_pkg::reg_addr_t i_awaddr;
	logic o_awready;
	logic i_wvalid;
	video_pixel_pkg::vram_word_t i_wdata;
	logic o_wready;
	logic o_bvalid;
	video_bus_pkg::axil_resp_t o_bresp;
	logic i_bready;
	logic i_arvalid;
	video_bus_pkg::reg_addr_t i_araddr;
	logic o_arready;
	logic o_rvalid;
	video_pixel_pkg::vram_word_t o_rdata;
	video_bus_pkg::axil_resp_t o_rresp;
	logic i_rready;
	logic i_hblank;
	logic i_vblank;
	video_pixel_pkg::coord_t i_pos_x;
	video_pixel_pkg::coord_t i_pos_y;
	logic o_vram_request;
	video_pixel_pkg::vram_word_t o_vram_address;
	video_pixel_pkg::vram_word_t i_vram_rdata;
	logic i_vram_ready;
	video_pixel_pkg::rgb_t o_pixel;

	// Reference model state.
	video_pixel_pkg::rgb_t pal_model [`VIDEO_PALETTE_SIZE];
	bit pal_known [`VIDEO_PALETTE_SIZE];
	video_pixel_pkg::vram_word_t line_model [MAXP];
	bit line_known [MAXP];
	video_pixel_pkg::vram_word_t m_read_offset;
	int m_pitch;
	int m_skip_x;
	int m_skip_y;
	logic m_use_pal;
	int mr;

	logic [31:0] rng_main;
	logic [31:0] rng_vram;
	logic [1:0] vram_wait;
	int cycle_count;

	// Expected pixel delay line matching the DUT pipeline.
	video_pixel_pkg::rgb_t cur_exp;
	logic cur_chk;
	video_pixel_pkg::rgb_t exp_d1;
	video_pixel_pkg::rgb_t exp_d2;
	video_pixel_pkg::rgb_t exp_d3;
	logic chk_d1;
	logic chk_d2;
	logic chk_d3;

	video_controller_top i_video_controller_top (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_awvalid(i_awvalid),
		.i_awaddr(i_awaddr),
		.o_awready(o_awready),
		.i_wvalid(i_wvalid),
		.i_wdata(i_wdata),
		.o_wready(o_wready),
		.o_bvalid(o_bvalid),
		.o_bresp(o_bresp),
		.i_bready(i_bready),
		.i_arvalid(i_arvalid),
		.i_araddr(i_araddr),
		.o_arready(o_arready),
		.o_rvalid(o_rvalid),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.i_rready(i_rready),
		.i_hblank(i_hblank),
		.i_vblank(i_vblank),
		.i_pos_x(i_pos_x),
		.i_pos_y(i_pos_y),
		.o_vram_request(o_vram_request),
		.o_vram_address(o_vram_address),
		.i_vram_rdata(i_vram_rdata),
		.i_vram_ready(i_vram_ready),
		.o_pixel(o_pixel)
	);

	initial i_clock = 1'b0;
	always #5 i_clock = ~i_clock;

	// ====================
	// Random numbers and checks.
	// ====================
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_main = lcg_step(rng_main);
		return rng_main ^ (rng_main >> 16);
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] v;
		v = rand_word();
		return int'(v % 32'(n));
	endfunction

	task automatic fail_stop();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_resp(input string name, input video_bus_pkg::axil_resp_t act,
		input video_bus_pkg::axil_resp_t exp);
		if (act !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
			fail_stop();
		end
	endtask

	task automatic check_rdata(input string name, input video_pixel_pkg::vram_word_t act,
		input video_pixel_pkg::vram_word_t exp);
		if (act !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
			fail_stop();
		end
	endtask

	task automatic check_pixel(input video_pixel_pkg::rgb_t act,
		input video_pixel_pkg::rgb_t exp);
		if (act !== exp) begin
			$display("mismatch at %0t: o_pixel got %h expected %h", $time, act, exp);
			fail_stop();
		end
	endtask

	task automatic check_level(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
			fail_stop();
		end
	endtask

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			fail_stop();
		end
	end

	always @(posedge i_clock) begin
		if (!i_rst_n) begin
			chk_d1 <= 1'b0;
			chk_d2 <= 1'b0;
			chk_d3 <= 1'b0;
		end else begin
			exp_d1 <= cur_exp;
			exp_d2 <= exp_d1;
			exp_d3 <= exp_d2;
			chk_d1 <= cur_chk;
			chk_d2 <= chk_d1;
			chk_d3 <= chk_d2;
		end
	end

	// Output is stable between edges.
	always @(negedge i_clock) begin
		if (chk_d3) begin
			check_pixel(o_pixel, exp_d3);
		end
	end

	// VRAM responder with 0 to 3 wait cycles per beat.
	initial begin
		rng_vram = 32'd92323;
		i_vram_ready <= 1'b0;
		i_vram_rdata <= '0;
		vram_wait <= 2'd0;
		forever begin
			@(posedge i_clock);
			if (!i_rst_n) begin
				i_vram_ready <= 1'b0;
				vram_wait <= 2'd0;
			end else begin
				i_vram_ready <= 1'b0;
				if (o_vram_request && !i_vram_ready) begin
					if (vram_wait == 2'd0) begin
						i_vram_ready <= 1'b1;
						i_vram_rdata <= o_vram_address ^ VRAM_XOR;
						rng_vram = lcg_step(rng_vram);
						vram_wait <= rng_vram[17:16];
					end else begin
						vram_wait <= vram_wait - 2'd1;
					end
				end
			end
		end
	end

	// ====================
	// Register model and bus tasks.
	// ====================
	task automatic model_write(input video_bus_pkg::reg_addr_t addr,
		input video_pixel_pkg::vram_word_t data);
		if (addr[11:10] == 2'b00) begin
			pal_model[addr[9:2]] = data[23:0];
			pal_known[addr[9:2]] = 1'b1;
		end else begin
			case (addr)
				`VIDEO_REG_READ_OFFSET: m_read_offset = data;
				`VIDEO_REG_PITCH: m_pitch = (data > 32'(MAXP)) ? MAXP : int'(data);
				`VIDEO_REG_SKIP_X: m_skip_x = int'(data[10:0]);
				`VIDEO_REG_SKIP_Y: m_skip_y = int'(data[10:0]);
				`VIDEO_REG_USE_PALETTE: m_use_pal = data[0];
				default: ;
			endcase
		end
	endtask

	function automatic video_pixel_pkg::vram_word_t expected_reg(
		input video_bus_pkg::reg_addr_t addr);
		case (addr)
			`VIDEO_REG_READ_OFFSET: return m_read_offset;
			`VIDEO_REG_PITCH: return 32'(m_pitch);
			`VIDEO_REG_SKIP_X: return 32'(m_skip_x);
			`VIDEO_REG_SKIP_Y: return 32'(m_skip_y);
			`VIDEO_REG_USE_PALETTE: return {31'd0, m_use_pal};
			default: return '0;
		endcase
	endfunction

	// Address and data go out with independent random delays.
	task automatic axil_write(input video_bus_pkg::reg_addr_t addr,
		input video_pixel_pkg::vram_word_t data);
		int aw_delay;
		int w_delay;
		int hold;
		int c;
		logic aw_pend;
		logic w_pend;
		logic aw_on;
		logic w_on;
		logic aw_fire;
		logic w_fire;
		video_bus_pkg::axil_resp_t first;
		aw_delay = rand_below(3);
		w_delay = rand_below(3);
		hold = rand_below(4);
		aw_pend = 1'b1;
		w_pend = 1'b1;
		aw_on = 1'b0;
		w_on = 1'b0;
		aw_fire = 1'b0;
		w_fire = 1'b0;
		c = 0;
		while (aw_pend || w_pend || aw_fire || w_fire) begin
			@(posedge i_clock);
			if (aw_fire) begin
				i_awvalid <= 1'b0;
				aw_fire = 1'b0;
			end
			if (w_fire) begin
				i_wvalid <= 1'b0;
				w_fire = 1'b0;
			end
			if (aw_pend && !aw_on && c >= aw_delay) begin
				i_awvalid <= 1'b1;
				i_awaddr <= addr;
				aw_on = 1'b1;
			end
			if (w_pend && !w_on && c >= w_delay) begin
				i_wvalid <= 1'b1;
				i_wdata <= data;
				w_on = 1'b1;
			end
			@(negedge i_clock);
			if (aw_on && o_awready) begin
				aw_fire = 1'b1;
				aw_on = 1'b0;
				aw_pend = 1'b0;
			end
			if (w_on && o_wready) begin
				w_fire = 1'b1;
				w_on = 1'b0;
				w_pend = 1'b0;
			end
			c++;
		end
		while (!o_bvalid) @(negedge i_clock);
		first = o_bresp;
		// Response must hold while bready stays low.
		repeat (hold) begin
			@(negedge i_clock);
			check_level("o_bvalid", o_bvalid, 1'b1);
			check_resp("o_bresp", o_bresp, first);
		end
		@(posedge i_clock);
		i_bready <= 1'b1;
		@(posedge i_clock);
		i_bready <= 1'b0;
		@(negedge i_clock);
		check_level("o_bvalid", o_bvalid, 1'b0);
		check_resp("o_bresp", first, video_bus_pkg::AXIL_OKAY);
		model_write(addr, data);
	endtask

	task automatic axil_read(input video_bus_pkg::reg_addr_t addr,
		output video_pixel_pkg::vram_word_t data, output video_bus_pkg::axil_resp_t resp);
		int delay;
		int hold;
		delay = rand_below(3);
		hold = rand_below(4);
		repeat (delay) @(posedge i_clock);
		@(posedge i_clock);
		i_arvalid <= 1'b1;
		i_araddr <= addr;
		@(negedge i_clock);
		while (!o_arready) @(negedge i_clock);
		@(posedge i_clock);
		i_arvalid <= 1'b0;
		@(negedge i_clock);
		while (!o_rvalid) @(negedge i_clock);
		data = o_rdata;
		resp = o_rresp;
		repeat (hold) begin
			@(negedge i_clock);
			check_level("o_rvalid", o_rvalid, 1'b1);
			check_rdata("o_rdata", o_rdata, data);
			check_resp("o_rresp", o_rresp, resp);
		end
		@(posedge i_clock);
		i_rready <= 1'b1;
		@(posedge i_clock);
		i_rready <= 1'b0;
		@(negedge i_clock);
		check_level("o_rvalid", o_rvalid, 1'b0);
	endtask

	task automatic read_and_compare(input video_bus_pkg::reg_addr_t addr,
		input video_pixel_pkg::vram_word_t exp_data, input video_bus_pkg::axil_resp_t exp_resp);
		video_pixel_pkg::vram_word_t data;
		video_bus_pkg::axil_resp_t resp;
		axil_read(addr, data, resp);
		check_resp("o_rresp", resp, exp_resp);
		check_rdata("o_rdata", data, exp_data);
	endtask

	task automatic set_video_mode(input video_pixel_pkg::vram_word_t offset, input int pitch,
		input int sx, input int sy, input logic pal);
		axil_write(`VIDEO_REG_READ_OFFSET, offset);
		axil_write(`VIDEO_REG_PITCH, 32'(pitch));
		axil_write(`VIDEO_REG_SKIP_X, 32'(sx));
		axil_write(`VIDEO_REG_SKIP_Y, 32'(sy));
		axil_write(`VIDEO_REG_USE_PALETTE, {31'd0, pal});
	endtask

	// ====================
	// Frame driving and pixel model.
	// ====================
	task automatic compute_expected(input int x, input int y,
		output video_pixel_pkg::rgb_t value, output logic known);
		int u;
		int idx;
		int b;
		video_pixel_pkg::vram_word_t word;
		video_pixel_pkg::pal_index_t pi;
		value = '0;
		known = 1'b1;
		if (x >= m_skip_x && x < W - m_skip_x && y >= m_skip_y && y < H - m_skip_y) begin
			u = x - m_skip_x;
			if (m_use_pal) begin
				idx = u / 4;
				b = u % 4;
			end else begin
				idx = u;
				b = 0;
			end
			idx = idx % MAXP;
			word = line_model[idx];
			known = line_known[idx];
			if (m_use_pal) begin
				pi = word[8*b +: 8];
				value = pal_model[pi];
				known = known && pal_known[pi];
			end else begin
				value = word[23:0];
			end
		end
	endtask

	// Holds hblank until the row fetch has finished.
	task automatic run_hblank();
		int i;
		@(posedge i_clock);
		i_hblank <= 1'b1;
		cur_chk <= 1'b0;
		if (mr >= m_skip_y && mr < H - m_skip_y) begin
			for (i = 0; i < m_pitch; i++) begin
				line_model[i] = (m_read_offset + 32'((mr - m_skip_y) * m_pitch * 4 + 4 * i))
					^ VRAM_XOR;
				line_known[i] = 1'b1;
			end
		end
		mr++;
		repeat (3) @(posedge i_clock);
		@(negedge i_clock);
		while (o_vram_request) @(negedge i_clock);
		repeat (2) @(posedge i_clock);
		i_hblank <= 1'b0;
	endtask

	task automatic drive_row(input int y);
		int x;
		video_pixel_pkg::rgb_t e;
		logic k;
		for (x = 0; x < W; x++) begin
			compute_expected(x, y, e, k);
			@(posedge i_clock);
			i_pos_x <= video_pixel_pkg::coord_t'(x);
			i_pos_y <= video_pixel_pkg::coord_t'(y);
			cur_exp <= e;
			cur_chk <= k;
		end
	endtask

	task automatic run_frame();
		int r;
		@(posedge i_clock);
		i_vblank <= 1'b1;
		mr = 0;
		repeat (4) @(posedge i_clock);
		i_vblank <= 1'b0;
		repeat (3) @(posedge i_clock);
		for (r = 0; r < H; r++) begin
			run_hblank();
			drive_row(r);
		end
		@(posedge i_clock);
		cur_chk <= 1'b0;
		repeat (4) @(posedge i_clock);
	endtask

	// ====================
	// Test sequence.
	// ====================
	initial begin
		int n;
		int sel;
		video_bus_pkg::reg_addr_t addr;
		video_pixel_pkg::vram_word_t data;
		rng_main = 32'd92323;
		for (n = 0; n < `VIDEO_PALETTE_SIZE; n++) begin
			pal_known[n] = 1'b0;
		end
		for (n = 0; n < MAXP; n++) begin
			line_known[n] = 1'b0;
		end
		// Register values after reset.
		m_read_offset = '0;
		m_pitch = MAXP;
		m_skip_x = 0;
		m_skip_y = 0;
		m_use_pal = 1'b1;
		mr = 0;
		i_rst_n <= 1'b0;
		i_awvalid <= 1'b0;
		i_awaddr <= '0;
		i_wvalid <= 1'b0;
		i_wdata <= '0;
		i_bready <= 1'b0;
		i_arvalid <= 1'b0;
		i_araddr <= '0;
		i_rready <= 1'b0;
		i_hblank <= 1'b0;
		i_vblank <= 1'b0;
		i_pos_x <= '0;
		i_pos_y <= '0;
		cur_exp <= '0;
		cur_chk <= 1'b0;
		repeat (2) @(posedge i_clock);
		i_rst_n <= 1'b1;
		@(negedge i_clock);
		check_level("o_awready", o_awready, 1'b0);
		check_level("o_wready", o_wready, 1'b0);
		check_level("o_arready", o_arready, 1'b1);
		check_level("o_bvalid", o_bvalid, 1'b0);
		check_level("o_rvalid", o_rvalid, 1'b0);
		check_level("o_vram_request", o_vram_request, 1'b0);
		check_pixel(o_pixel, '0);
		@(negedge i_clock);
		check_level("o_awready", o_awready, 1'b1);
		check_level("o_wready", o_wready, 1'b1);
		for (n = 0; n < 5; n++) begin
			addr = video_bus_pkg::reg_addr_t'(32'h400 + 4 * n);
			read_and_compare(addr, expected_reg(addr), video_bus_pkg::AXIL_OKAY);
		end

		// Random register and palette traffic.
		for (n = 0; n < 24; n++) begin
			sel = rand_below(6);
			data = rand_word();
			if (sel == 5) begin
				addr = video_bus_pkg::reg_addr_t'(4 * rand_below(256));
				axil_write(addr, data);
				read_and_compare(addr, '0, video_bus_pkg::AXIL_SLVERR);
			end else begin
				addr = video_bus_pkg::reg_addr_t'(32'h400 + 4 * sel);
				axil_write(addr, data);
				read_and_compare(addr, expected_reg(addr), video_bus_pkg::AXIL_OKAY);
			end
		end
		for (n = 0; n < 8; n++) begin
			addr = video_bus_pkg::reg_addr_t'(32'h414 + 4 * rand_below(200));
			read_and_compare(addr, '0, video_bus_pkg::AXIL_SLVERR);
		end

		// Palette mode over a full random palette.
		for (n = 0; n < `VIDEO_PALETTE_SIZE; n++) begin
			axil_write(video_bus_pkg::reg_addr_t'(4 * n), rand_word());
		end
		set_video_mode(rand_word() & 32'h000F_FFFC, MAXP, 0, 0, 1'b1);
		run_frame();

		// Direct mode with an offset and a shorter pitch.
		set_video_mode(rand_word() & 32'h00FF_FFFC, 16 + rand_below(48), 0, 0, 1'b0);
		run_frame();

		// Border window in both modes.
		set_video_mode(rand_word() & 32'h000F_FFFC, MAXP, rand_below(24), rand_below(6), 1'b1);
		run_frame();
		set_video_mode(rand_word() & 32'h000F_FFFC, MAXP, rand_below(24), rand_below(6), 1'b0);
		run_frame();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hw
hw/video_bus_pkg.sv
hw/video_pixel_pkg.sv
hw/video_dual_port_ram.sv
hw/video_axil_regs.sv
hw/video_line_fetch.sv
hw/video_pixel_out.sv
hw/video_controller_top.sv
sim/tb_video_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_video_controller \
	-f list.f \
	-Mdir obj_dir -o sim_video_controller

# The simulator exits nonzero on a fatal stop, so the log decides.
./obj_dir/sim_video_controller > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
